/* source/axiMem_settings.svh */
/*
 * AXI memory slave settings
 * Bus, ID and burst length widths plus the memory depth, shared by every
 * block of the slave and by its testbench
 */

`ifndef AXIMEM_SETTINGS_SVH
`define AXIMEM_SETTINGS_SVH

// Bus widths ------------------------------
`define AXIMEM_ADDR_WIDTH 32 // Byte address
`define AXIMEM_DATA_WIDTH 32 // One word per beat, strobes are this over 8

// Transaction fields
`define AXIMEM_ID_WIDTH   4  // Echoed on B and R
`define AXIMEM_LEN_WIDTH  8  // AXI4 AxLEN, up to 256 beats

// Storage ---------------------------------
// 256 words of 32 bits, 1 KiB
`define AXIMEM_DEPTH      256

`endif

/* source/axiMemPkg.sv */
/*
 * AXI memory slave types
 * Burst, response and transfer size encodings used on both channels
 */

package axiMemPkg;

	// Burst types ------------------------------
	// AxBURST encoding
	typedef enum logic [1:0] {
		FIXED = 2'b00, // Same address every beat
		INCR  = 2'b01, // Address steps by the beat size
		WRAP  = 2'b10, // Steps and wraps in an aligned window
		RSVD  = 2'b11  // Reserved, answered with SLVERR
	} axiBurst_t;

	// Responses --------------------------------
	// BRESP and RRESP encoding
	typedef enum logic [1:0] {
		OKAY   = 2'b00, // Normal access done
		EXOKAY = 2'b01, // Exclusive ok, never sent here
		SLVERR = 2'b10, // Slave error
		DECERR = 2'b11  // Decode error, never sent here
	} axiResp_t;

	// Transfer size ----------------------------
	// AxSIZE, bytes per beat = 2 ** code
	// 0 byte, 1 halfword, 2 word, above that wider than the 32-bit bus
	typedef logic [2:0] axiSize_t;

endpackage

/* source/memPortIf.sv */
/*
 * Memory write port
 * Word index, data and byte enables from the write channel to the array
 */

`timescale 1ns/10ps
`include "axiMem_settings.svh"

interface memPortIf;

	logic                              we;    // Write this cycle
	logic [$clog2(`AXIMEM_DEPTH)-1:0]  addr;  // Word index
	logic [`AXIMEM_DATA_WIDTH-1:0]     wdata;
	logic [`AXIMEM_DATA_WIDTH/8-1:0]   wstrb; // One bit per byte lane

	// Write channel side
	modport writer (
		output we,
		output addr,
		output wdata,
		output wstrb
	);

	// Array side
	modport memory (
		input we,
		input addr,
		input wdata,
		input wstrb
	);

endinterface

/* source/axiBurstAddr.sv */
/*
 * AXI burst address step
 * Next beat address for FIXED, INCR and WRAP, and burst legality check
 */

`timescale 1ns/10ps
`include "axiMem_settings.svh"

module axiBurstAddr
	import axiMemPkg::*;
(
	input  logic [`AXIMEM_ADDR_WIDTH-1:0] addr,     // Current beat
	input  axiSize_t                      size,
	input  logic [`AXIMEM_LEN_WIDTH-1:0]  len,      // Beats minus one
	input  axiBurst_t                     burst,
	output logic [`AXIMEM_ADDR_WIDTH-1:0] nextAddr,
	output logic                          legal
);

	localparam int maxSize = $clog2(`AXIMEM_DATA_WIDTH / 8); // Full bus width code

	logic [`AXIMEM_ADDR_WIDTH-1:0] beatBytes;
	logic [`AXIMEM_ADDR_WIDTH-1:0] alignedAddr;
	logic [`AXIMEM_ADDR_WIDTH-1:0] incrAddr;
	logic [`AXIMEM_ADDR_WIDTH-1:0] wrapMask;
	logic                          wrapLenOk;

	// Step ------------------------------
	assign beatBytes   = 1 << size;
	assign alignedAddr = addr & ~(beatBytes - 1'b1); // Later beats are aligned
	assign incrAddr    = alignedAddr + beatBytes;

	// Window is (len + 1) beats
	assign wrapMask  = (beatBytes * (len + 1'b1)) - 1'b1;
	assign wrapLenOk = (len == 1) || (len == 3) || (len == 7) || (len == 15);

	always_comb begin
		case (burst)
			FIXED:   nextAddr = addr;
			INCR:    nextAddr = incrAddr;
			WRAP:    nextAddr = (addr & ~wrapMask) | (incrAddr & wrapMask); // Stay in window
			default: nextAddr = addr; // Reserved, beats are discarded anyway
		endcase
	end

	// Legality ------------------------------
	// Reserved type, too wide a size, or a bad WRAP length
	assign legal = (burst != RSVD) && (size <= maxSize) && ((burst != WRAP) || wrapLenOk);

endmodule

/* source/axiMemArray.sv */
/*
 * Word memory of the slave
 * Byte enabled write port and one read port with a registered output
 */

`timescale 1ns/10ps
`include "axiMem_settings.svh"

module axiMemArray (
	input  logic                             CLK,
	memPortIf.memory                         mem,
	input  logic                             re,     // Read enable
	input  logic [$clog2(`AXIMEM_DEPTH)-1:0] rdAddr, // Word index
	output logic [`AXIMEM_DATA_WIDTH-1:0]    rdData  // Valid the cycle after re
);

	localparam int lanes = `AXIMEM_DATA_WIDTH / 8;

	logic [`AXIMEM_DATA_WIDTH-1:0] memWords [`AXIMEM_DEPTH];

	// Write port ------------------------------
	// Only strobed lanes change
	always_ff @(posedge CLK) begin
		if (mem.we) begin
			for (int i = 0; i < lanes; i++) begin
				if (mem.wstrb[i])
					memWords[mem.addr][8*i +: 8] <= mem.wdata[8*i +: 8];
			end
		end
	end

	// Read port ------------------------------
	// Output held while re is low
	always_ff @(posedge CLK) begin
		if (re)
			rdData <= memWords[rdAddr];
	end

endmodule

/* source/axiWriteChannel.sv */
/*
 * AXI write channel
 * Takes one AW request, writes each W beat under its strobes and answers on B
 */

`timescale 1ns/10ps
`include "axiMem_settings.svh"

module axiWriteChannel
	import axiMemPkg::*;
(
	input  logic                            CLK,
	input  logic                            reset,
	// Write address
	input  logic [`AXIMEM_ID_WIDTH-1:0]     AWID,
	input  logic [`AXIMEM_ADDR_WIDTH-1:0]   AWADDR,
	input  logic [`AXIMEM_LEN_WIDTH-1:0]    AWLEN,
	input  axiSize_t                        AWSIZE,
	input  logic [1:0]                      AWBURST,
	input  logic                            AWVALID,
	output logic                            AWREADY,
	// Write data
	input  logic [`AXIMEM_DATA_WIDTH-1:0]   WDATA,
	input  logic [`AXIMEM_DATA_WIDTH/8-1:0] WSTRB,
	input  logic                            WLAST,
	input  logic                            WVALID,
	output logic                            WREADY,
	// Write response
	output logic [`AXIMEM_ID_WIDTH-1:0]     BID,
	output axiResp_t                        BRESP,
	output logic                            BVALID,
	input  logic                            BREADY,
	// Memory
	memPortIf.writer                        mem
);

	localparam int laneBits = $clog2(`AXIMEM_DATA_WIDTH / 8); // Byte offset bits
	localparam int idxWidth = $clog2(`AXIMEM_DEPTH);

	typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_RESP} wrState_t;

	wrState_t                      state;
	logic [`AXIMEM_ADDR_WIDTH-1:0] beatAddr;  // Address of the beat now on W
	logic [`AXIMEM_ADDR_WIDTH-1:0] nextAddr;
	axiSize_t                      beatSize;
	logic [`AXIMEM_LEN_WIDTH-1:0]  beatLen;
	axiBurst_t                     beatBurst;
	logic                          burstLegal;
	logic                          inRange;
	logic                          beatOk;
	logic                          errFlag;   // Sticky over the burst
	logic                          wBeat;

	axiBurstAddr burstStep (
		.addr     (beatAddr),
		.size     (beatSize),
		.len      (beatLen),
		.burst    (beatBurst),
		.nextAddr (nextAddr),
		.legal    (burstLegal)
	);

	// Beat check ------------------------------
	assign wBeat   = WVALID && WREADY;
	assign inRange = (beatAddr >> laneBits) < `AXIMEM_DEPTH;
	assign beatOk  = burstLegal && inRange;

	// Memory written on the W handshake edge
	assign mem.we    = wBeat && beatOk; // Bad beats dropped
	assign mem.addr  = beatAddr[laneBits +: idxWidth];
	assign mem.wdata = WDATA;
	assign mem.wstrb = WSTRB;

	// Control FSM ------------------------------
	always_ff @(posedge CLK) begin
		if (reset) begin
			state   <= WR_IDLE;
			AWREADY <= 1'b0;
			WREADY  <= 1'b0;
			BVALID  <= 1'b0;
			errFlag <= 1'b0;
		end else begin
			case (state)
				WR_IDLE: begin
					if (AWVALID && AWREADY) begin
						AWREADY <= 1'b0;
						WREADY  <= 1'b1; // Data accepted from next cycle
						errFlag <= 1'b0;
						state   <= WR_DATA;
					end else begin
						AWREADY <= 1'b1;
					end
				end
				WR_DATA: begin
					if (wBeat) begin
						errFlag <= errFlag | ~beatOk;
						if (WLAST) begin
							WREADY <= 1'b0;
							BVALID <= 1'b1;
							state  <= WR_RESP;
						end
					end
				end
				WR_RESP: begin
					if (BREADY) begin // BVALID is high here
						BVALID  <= 1'b0;
						AWREADY <= 1'b1;
						state   <= WR_IDLE;
					end
				end
				default: state <= WR_IDLE;
			endcase
		end
	end

	// Request and response payload
	always_ff @(posedge CLK) begin
		if (AWVALID && AWREADY) begin
			BID       <= AWID; // Echoed on B
			beatAddr  <= AWADDR;
			beatLen   <= AWLEN;
			beatSize  <= AWSIZE;
			beatBurst <= axiBurst_t'(AWBURST);
		end else if (wBeat) begin
			beatAddr <= nextAddr;
		end
		if (wBeat && WLAST)
			BRESP <= (errFlag || !beatOk) ? SLVERR : OKAY; // Any bad beat fails all
	end

endmodule

/* source/axiReadChannel.sv */
/*
 * AXI read channel
 * Takes one AR request and returns its beats one at a time from the array
 */

`timescale 1ns/10ps
`include "axiMem_settings.svh"

module axiReadChannel
	import axiMemPkg::*;
(
	input  logic                             CLK,
	input  logic                             reset,
	// Read address
	input  logic [`AXIMEM_ID_WIDTH-1:0]      ARID,
	input  logic [`AXIMEM_ADDR_WIDTH-1:0]    ARADDR,
	input  logic [`AXIMEM_LEN_WIDTH-1:0]     ARLEN,
	input  axiSize_t                         ARSIZE,
	input  logic [1:0]                       ARBURST,
	input  logic                             ARVALID,
	output logic                             ARREADY,
	// Read data
	output logic [`AXIMEM_ID_WIDTH-1:0]      RID,
	output logic [`AXIMEM_DATA_WIDTH-1:0]    RDATA,
	output axiResp_t                         RRESP,
	output logic                             RLAST,
	output logic                             RVALID,
	input  logic                             RREADY,
	// Memory read port
	output logic                             re,
	output logic [$clog2(`AXIMEM_DEPTH)-1:0] rdAddr,
	input  logic [`AXIMEM_DATA_WIDTH-1:0]    rdData
);

	localparam int laneBits = $clog2(`AXIMEM_DATA_WIDTH / 8);
	localparam int idxWidth = $clog2(`AXIMEM_DEPTH);

	typedef enum logic [1:0] {RD_IDLE, RD_FETCH, RD_DELIVER} rdState_t;

	rdState_t                      state;
	logic [`AXIMEM_ADDR_WIDTH-1:0] beatAddr;
	logic [`AXIMEM_ADDR_WIDTH-1:0] nextAddr;
	axiSize_t                      beatSize;
	logic [`AXIMEM_LEN_WIDTH-1:0]  beatLen;
	axiBurst_t                     beatBurst;
	logic [`AXIMEM_LEN_WIDTH-1:0]  beatsLeft; // Beats after the current one
	logic                          burstLegal;
	logic                          inRange;
	logic                          beatOk;
	logic                          beatErr;   // Beat on R is zeroed
	logic                          rBeat;

	axiBurstAddr burstStep (
		.addr     (beatAddr),
		.size     (beatSize),
		.len      (beatLen),
		.burst    (beatBurst),
		.nextAddr (nextAddr),
		.legal    (burstLegal)
	);

	// Fetch ------------------------------
	assign rBeat   = RVALID && RREADY;
	assign inRange = (beatAddr >> laneBits) < `AXIMEM_DEPTH;
	assign beatOk  = burstLegal && inRange;

	assign re     = (state == RD_FETCH) && beatOk; // One read per good beat
	assign rdAddr = beatAddr[laneBits +: idxWidth];

	// Array output holds its word until the next re, so RDATA is steady under stall
	assign RDATA = beatErr ? '0 : rdData;

	// Control FSM ------------------------------
	always_ff @(posedge CLK) begin
		if (reset) begin
			state   <= RD_IDLE;
			ARREADY <= 1'b0;
			RVALID  <= 1'b0;
		end else begin
			case (state)
				RD_IDLE: begin
					if (ARVALID && ARREADY) begin
						ARREADY <= 1'b0;
						state   <= RD_FETCH;
					end else begin
						ARREADY <= 1'b1;
					end
				end
				RD_FETCH: begin
					RVALID <= 1'b1; // Word arrives with it
					state  <= RD_DELIVER;
				end
				RD_DELIVER: begin
					if (RREADY) begin
						RVALID <= 1'b0;
						if (RLAST) begin
							ARREADY <= 1'b1;
							state   <= RD_IDLE;
						end else begin
							state <= RD_FETCH; // Next address next cycle
						end
					end
				end
				default: state <= RD_IDLE;
			endcase
		end
	end

	// Request and beat payload
	always_ff @(posedge CLK) begin
		if (ARVALID && ARREADY) begin
			RID       <= ARID;
			beatAddr  <= ARADDR;
			beatLen   <= ARLEN;
			beatSize  <= ARSIZE;
			beatBurst <= axiBurst_t'(ARBURST);
			beatsLeft <= ARLEN;
		end
		if (state == RD_FETCH) begin
			RRESP    <= beatOk ? OKAY : SLVERR;
			RLAST    <= (beatsLeft == '0);
			beatErr  <= !beatOk;
			beatAddr <= nextAddr;
		end
		if (rBeat && !RLAST)
			beatsLeft <= beatsLeft - 1'b1;
	end

endmodule

/* source/axiMemSlave.sv */
/*
 * AXI4 slave memory, top level
 * Independent write and read channels sharing a 256 x 32 word array
 */

`timescale 1ns/10ps
`include "axiMem_settings.svh"

module axiMemSlave
	import axiMemPkg::*;
(
	input  logic                            CLK,
	input  logic                            reset,
	// Write address
	input  logic [`AXIMEM_ID_WIDTH-1:0]     AWID,
	input  logic [`AXIMEM_ADDR_WIDTH-1:0]   AWADDR,
	input  logic [`AXIMEM_LEN_WIDTH-1:0]    AWLEN,
	input  axiSize_t                        AWSIZE,
	input  logic [1:0]                      AWBURST,
	input  logic                            AWVALID,
	output logic                            AWREADY,
	// Write data
	input  logic [`AXIMEM_DATA_WIDTH-1:0]   WDATA,
	input  logic [`AXIMEM_DATA_WIDTH/8-1:0] WSTRB,
	input  logic                            WLAST,
	input  logic                            WVALID,
	output logic                            WREADY,
	// Write response
	output logic [`AXIMEM_ID_WIDTH-1:0]     BID,
	output axiResp_t                        BRESP,
	output logic                            BVALID,
	input  logic                            BREADY,
	// Read address
	input  logic [`AXIMEM_ID_WIDTH-1:0]     ARID,
	input  logic [`AXIMEM_ADDR_WIDTH-1:0]   ARADDR,
	input  logic [`AXIMEM_LEN_WIDTH-1:0]    ARLEN,
	input  axiSize_t                        ARSIZE,
	input  logic [1:0]                      ARBURST,
	input  logic                            ARVALID,
	output logic                            ARREADY,
	// Read data
	output logic [`AXIMEM_ID_WIDTH-1:0]     RID,
	output logic [`AXIMEM_DATA_WIDTH-1:0]   RDATA,
	output axiResp_t                        RRESP,
	output logic                            RLAST,
	output logic                            RVALID,
	input  logic                            RREADY
);

	// Read port wires
	logic                             re;
	logic [$clog2(`AXIMEM_DEPTH)-1:0] rdAddr;
	logic [`AXIMEM_DATA_WIDTH-1:0]    rdData;

	memPortIf memBus (); // Write port

	axiWriteChannel writeChan (
		.CLK, .reset,
		.AWID, .AWADDR, .AWLEN, .AWSIZE, .AWBURST, .AWVALID, .AWREADY,
		.WDATA, .WSTRB, .WLAST, .WVALID, .WREADY,
		.BID, .BRESP, .BVALID, .BREADY,
		.mem (memBus.writer)
	);

	axiReadChannel readChan (
		.CLK, .reset,
		.ARID, .ARADDR, .ARLEN, .ARSIZE, .ARBURST, .ARVALID, .ARREADY,
		.RID, .RDATA, .RRESP, .RLAST, .RVALID, .RREADY,
		.re, .rdAddr, .rdData
	);

	axiMemArray memArray (
		.CLK,
		.mem (memBus.memory),
		.re, .rdAddr, .rdData
	);

endmodule

/* verif/axiMemSlaveTb.sv */
/*
 * Testbench of the AXI4 slave memory
 * Applies a table of bursts, keeps a byte reference model and checks B and R
 * with random BREADY and RREADY back-pressure from a Galois LFSR
 */

`timescale 1ns/10ps
`include "axiMem_settings.svh"

module axiMemSlaveTb
	import axiMemPkg::*;
();

	localparam int lanes    = `AXIMEM_DATA_WIDTH / 8;
	localparam int memBytes = `AXIMEM_DEPTH * lanes;
	localparam int rowCount = 24;

	typedef struct packed {
		logic                          isWrite;
		logic [`AXIMEM_ID_WIDTH-1:0]   id;
		logic [`AXIMEM_ADDR_WIDTH-1:0] addr;
		logic [`AXIMEM_LEN_WIDTH-1:0]  len;
		axiSize_t                      size;
		axiBurst_t                     burst;
		axiResp_t                      resp;   // B response or worst R beat
	} stimRow_t;

	logic CLK, reset;
	logic [`AXIMEM_ID_WIDTH-1:0] AWID, BID, ARID, RID;
	logic [`AXIMEM_ADDR_WIDTH-1:0] AWADDR, ARADDR;
	logic [`AXIMEM_LEN_WIDTH-1:0] AWLEN, ARLEN;
	axiSize_t AWSIZE, ARSIZE;
	logic [1:0] AWBURST, ARBURST;
	logic AWVALID, AWREADY, WLAST, WVALID, WREADY, BVALID, BREADY;
	logic ARVALID, ARREADY, RLAST, RVALID, RREADY;
	logic [`AXIMEM_DATA_WIDTH-1:0] WDATA, RDATA;
	logic [lanes-1:0] WSTRB;
	axiResp_t BRESP, RRESP;

	stimRow_t   rows [rowCount];
	logic [7:0] refMem [memBytes]; // Byte model of the array
	logic [31:0] lfsrState;
	int cycles = 0;
	int cycleLimit = 0;

	axiMemSlave u_dut (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK; // 40 ns period
	end

	// Timeout watchdog
	always @(posedge CLK) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Timeout: the test table did not finish within %0d cycles", cycleLimit);
			abortRun();
		end
	end

	// Random source ------------------------------
	function automatic logic nextBit();
		logic outBit;
		outBit    = lfsrState[0];
		lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
		return outBit;
	endfunction

	function automatic logic [31:0] randomWord();
		logic [31:0] word;
		for (int i = 0; i < 32; i++)
			word = {word[30:0], nextBit()};
		return word;
	endfunction

	// Low on about one cycle in four
	function automatic logic randomReady();
		logic a;
		logic b;
		a = nextBit();
		b = nextBit();
		return !(a && b);
	endfunction

	// AXI address rules ------------------------------
	function automatic logic beatLegal(input stimRow_t row, input logic [31:0] addr);
		logic wrapOk;
		logic burstOk;
		wrapOk  = (row.len == 8'd1) || (row.len == 8'd3) || (row.len == 8'd7) || (row.len == 8'd15);
		burstOk = (row.burst != RSVD) && (row.size <= 3'd2) && ((row.burst != WRAP) || wrapOk);
		return burstOk && ((addr / lanes) < `AXIMEM_DEPTH);
	endfunction

	function automatic logic [31:0] nextBeatAddr(input stimRow_t row, input logic [31:0] addr);
		logic [31:0] bytes;
		logic [31:0] window;
		logic [31:0] base;
		logic [31:0] next;
		bytes  = 32'd1 << row.size;
		window = bytes * (32'(row.len) + 32'd1); // WRAP window in bytes
		base   = addr - (addr % window);
		next   = addr - (addr % bytes) + bytes;  // Aligned step
		case (row.burst)
			INCR:    return next;
			WRAP:    return (next >= base + window) ? base : next;
			default: return addr; // FIXED and reserved keep the address
		endcase
	endfunction

	// Lanes a master enables for one beat
	function automatic logic [lanes-1:0] laneStrobe(input stimRow_t row, input logic [31:0] addr);
		int bytes;
		int first;
		logic [lanes-1:0] strb;
		bytes = 1 << row.size;
		if (bytes >= lanes)
			return '1;
		first = int'(addr % lanes) & ~(bytes - 1);
		strb  = '0;
		for (int i = 0; i < bytes; i++)
			strb[first + i] = 1'b1;
		return strb;
	endfunction

	task automatic refWrite(input logic [31:0] addr, input logic [31:0] data,
		input logic [lanes-1:0] strb);
		int base;
		base = int'(addr / lanes) * lanes;
		for (int i = 0; i < lanes; i++)
			if (strb[i])
				refMem[base + i] = data[8*i +: 8];
	endtask

	function automatic logic [31:0] refWord(input logic [31:0] addr);
		int base;
		logic [31:0] word;
		base = int'(addr / lanes) * lanes;
		for (int i = 0; i < lanes; i++)
			word[8*i +: 8] = refMem[base + i];
		return word;
	endfunction

	// Checks ------------------------------
	task automatic abortRun();
		$display("STATUS: FAIL");
		$fatal(1, "Run stopped at the first failure");
	endtask

	task automatic checkResp(input string name, input axiResp_t got, input axiResp_t exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkData(input string name, input logic [`AXIMEM_DATA_WIDTH-1:0] got,
		input logic [`AXIMEM_DATA_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkId(input string name, input logic [`AXIMEM_ID_WIDTH-1:0] got,
		input logic [`AXIMEM_ID_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	task automatic checkLast(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("error %s: got 0x%h, expected 0x%h", name, got, exp);
			abortRun();
		end
	endtask

	// Bus drivers ------------------------------
	task automatic nextCycle();
		@(posedge CLK);
		#2; // Drive and sample away from the edge
	endtask

	task automatic writeBurst(input stimRow_t row);
		logic [31:0] addr;
		logic [31:0] data;
		logic [lanes-1:0] strb;
		logic accepted;
		AWID    = row.id;
		AWADDR  = row.addr;
		AWLEN   = row.len;
		AWSIZE  = row.size;
		AWBURST = row.burst;
		AWVALID = 1'b1;
		do begin
			accepted = AWREADY;
			nextCycle();
		end while (!accepted);
		AWVALID = 1'b0;
		addr = row.addr;
		for (int beat = 0; beat <= int'(row.len); beat++) begin
			data   = randomWord();
			strb   = laneStrobe(row, addr);
			WDATA  = data;
			WSTRB  = strb;
			WLAST  = (beat == int'(row.len));
			WVALID = 1'b1;
			do begin
				accepted = WREADY;
				nextCycle();
			end while (!accepted);
			if (beatLegal(row, addr))
				refWrite(addr, data, strb); // Bad beats leave memory alone
			addr = nextBeatAddr(row, addr);
		end
		WVALID = 1'b0;
		WLAST  = 1'b0;
		accepted = 1'b0;
		while (!accepted) begin
			BREADY   = randomReady();
			accepted = BVALID && BREADY;
			if (accepted) begin
				checkId("BID", BID, row.id);
				checkResp("BRESP", BRESP, row.resp);
			end
			nextCycle();
		end
		BREADY = 1'b0;
	endtask

	task automatic readBurst(input stimRow_t row);
		logic [31:0] addr;
		logic accepted;
		int beat;
		axiResp_t expResp;
		axiResp_t worst;
		ARID    = row.id;
		ARADDR  = row.addr;
		ARLEN   = row.len;
		ARSIZE  = row.size;
		ARBURST = row.burst;
		ARVALID = 1'b1;
		do begin
			accepted = ARREADY;
			nextCycle();
		end while (!accepted);
		ARVALID = 1'b0;
		addr  = row.addr;
		beat  = 0;
		worst = OKAY;
		while (beat <= int'(row.len)) begin
			RREADY = randomReady();
			if (RVALID && RREADY) begin
				if (beatLegal(row, addr))
					expResp = OKAY;
				else
					expResp = SLVERR;
				checkId($sformatf("RID beat %0d", beat), RID, row.id);
				checkResp($sformatf("RRESP beat %0d", beat), RRESP, expResp);
				checkData($sformatf("RDATA beat %0d", beat), RDATA,
					(expResp == OKAY) ? refWord(addr) : '0); // Zero on a bad beat
				checkLast($sformatf("RLAST beat %0d", beat), RLAST, beat == int'(row.len));
				if (RRESP != OKAY)
					worst = SLVERR;
				addr = nextBeatAddr(row, addr);
				beat++;
			end
			nextCycle();
		end
		RREADY = 1'b0;
		checkResp("RRESP of burst", worst, row.resp);
	endtask

	// Test table ------------------------------
	// op, ID, address, length, size, burst, expected response
	task automatic fillTable();
		rows[0]  = '{1'b1, 4'h1, 32'h000, 8'd3,   3'd2, INCR,  OKAY};   // Full words
		rows[1]  = '{1'b0, 4'h2, 32'h000, 8'd3,   3'd2, INCR,  OKAY};
		rows[2]  = '{1'b1, 4'h3, 32'h040, 8'd7,   3'd2, INCR,  OKAY};
		rows[3]  = '{1'b1, 4'h4, 32'h045, 8'd3,   3'd0, INCR,  OKAY};   // Bytes
		rows[4]  = '{1'b1, 4'h5, 32'h052, 8'd1,   3'd1, INCR,  OKAY};   // Halfwords
		rows[5]  = '{1'b0, 4'h6, 32'h040, 8'd7,   3'd2, INCR,  OKAY};
		rows[6]  = '{1'b1, 4'h7, 32'h080, 8'd3,   3'd2, FIXED, OKAY};   // Last beat stays
		rows[7]  = '{1'b0, 4'h8, 32'h080, 8'd0,   3'd2, INCR,  OKAY};
		rows[8]  = '{1'b1, 4'h9, 32'h0C0, 8'd3,   3'd2, INCR,  OKAY};
		rows[9]  = '{1'b1, 4'hA, 32'h0C8, 8'd3,   3'd2, WRAP,  OKAY};   // Mid window start
		rows[10] = '{1'b0, 4'hB, 32'h0C0, 8'd3,   3'd2, INCR,  OKAY};
		rows[11] = '{1'b0, 4'hC, 32'h0C8, 8'd3,   3'd2, WRAP,  OKAY};
		rows[12] = '{1'b1, 4'hD, 32'h3F8, 8'd3,   3'd2, INCR,  SLVERR}; // Runs off the end
		rows[13] = '{1'b0, 4'hE, 32'h3F8, 8'd3,   3'd2, INCR,  SLVERR};
		rows[14] = '{1'b1, 4'hF, 32'h000, 8'd1,   3'd2, RSVD,  SLVERR};
		rows[15] = '{1'b1, 4'h0, 32'h040, 8'd2,   3'd2, WRAP,  SLVERR}; // Three beat WRAP
		rows[16] = '{1'b1, 4'h1, 32'h000, 8'd1,   3'd3, INCR,  SLVERR}; // Wider than bus
		rows[17] = '{1'b0, 4'h2, 32'h000, 8'd3,   3'd2, INCR,  OKAY};   // Still unchanged
		rows[18] = '{1'b0, 4'h3, 32'h040, 8'd7,   3'd2, INCR,  OKAY};
		rows[19] = '{1'b0, 4'h4, 32'h0C0, 8'd1,   3'd3, INCR,  SLVERR};
		rows[20] = '{1'b0, 4'h5, 32'h000, 8'd1,   3'd2, RSVD,  SLVERR};
		rows[21] = '{1'b0, 4'h6, 32'h400, 8'd0,   3'd2, INCR,  SLVERR};
		rows[22] = '{1'b1, 4'h7, 32'h000, 8'd255, 3'd2, INCR,  OKAY};   // Whole array
		rows[23] = '{1'b0, 4'h8, 32'h000, 8'd255, 3'd2, INCR,  OKAY};
	endtask

	initial begin
		int totalBeats;
		lfsrState = 32'd88200;
		reset   = 1'b1;
		AWID    = '0;
		AWADDR  = '0;
		AWLEN   = '0;
		AWSIZE  = '0;
		AWBURST = '0;
		AWVALID = 1'b0;
		WDATA   = '0;
		WSTRB   = '0;
		WLAST   = 1'b0;
		WVALID  = 1'b0;
		BREADY  = 1'b0;
		ARID    = '0;
		ARADDR  = '0;
		ARLEN   = '0;
		ARSIZE  = '0;
		ARBURST = '0;
		ARVALID = 1'b0;
		RREADY  = 1'b0;
		fillTable();
		totalBeats = 0;
		for (int i = 0; i < rowCount; i++)
			totalBeats += int'(rows[i].len) + 1;
		cycleLimit = totalBeats * 8 + 200;
		repeat (10) @(posedge CLK);
		#2;
		reset = 1'b0;
		for (int i = 0; i < rowCount; i++) begin
			if (rows[i].isWrite)
				writeBurst(rows[i]);
			else
				readBurst(rows[i]);
		end
		$display("STATUS: PASS");
		$finish;
	end

endmodule

/* project.f */
+incdir+source
source/axiMemPkg.sv
source/memPortIf.sv
source/axiBurstAddr.sv
source/axiMemArray.sv
source/axiWriteChannel.sv
source/axiReadChannel.sv
source/axiMemSlave.sv
verif/axiMemSlaveTb.sv

/* Makefile */
# Verilator build and run of the AXI4 slave memory testbench
# The run exits with a failing status when the testbench stops on $fatal

VERILATOR ?= verilator
TOP       ?= axiMemSlaveTb
FLIST     ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
